/* include/oled_defs.svh */
`ifndef OLED_DEFS_SVH
`define OLED_DEFS_SVH

// config sequence length in bytes, AE first and AF last.
`define OLED_INIT_LEN 29

// panel geometry.
`define OLED_COLS  128
`define OLED_PAGES 8

// one glyph half, 16 columns of 8 pixels.
`define OLED_GLYPH_BYTES 16

// reset hold after en.
// panel reset is held low for the first OLED_RESET_LOW cycles of it.
`define OLED_RESET_CYCLES 5
`define OLED_RESET_LOW    3

`endif

/* include/oled_font.svh */
`ifndef OLED_FONT_SVH
`define OLED_FONT_SVH

// 16x16 glyphs 0..9 and A..F.
// each half is 16 column bytes, leftmost column in bits 127:120, lsb at the top row.
localparam logic [127:0] oled_font_top [16] = '{
    128'h00E0F018_08080808_0818F0E0_00000000,  // 0.
    128'h00000010_10F8F800_00000000_00000000,  // 1.
    128'h00307808_08080808_88F87000_00000000,  // 2.
    128'h00301808_88888888_D8703000_00000000,  // 3.
    128'h00000080_C0603010_F8F80000_00000000,  // 4.
    128'h00F8F888_88888888_08080000_00000000,  // 5.
    128'h00E0F098_88888888_98100000_00000000,  // 6.
    128'h00383808_08088868_38180000_00000000,  // 7.
    128'h0070F888_88888888_F8700000_00000000,  // 8.
    128'h00E0F018_08080808_18F0E000_00000000,  // 9.
    128'h000000C0_38E0C000_00000000_00000000,  // A.
    128'h08F8F888_888888D8_70000000_00000000,  // B.
    128'hC0E03018_08080808_18303800_00000000,  // C.
    128'h08F8F808_08080818_30E0C000_00000000,  // D.
    128'h08F8F888_888888E8_08100000_00000000,  // E.
    128'h08F8F888_888888E8_08100000_00000000   // F, same top as E.
};

localparam logic [127:0] oled_font_btm [16] = '{
    128'h000F1F30_20202020_20301F0F_00000000,  // 0.
    128'h00000020_203F3F20_20000000_00000000,  // 1.
    128'h00303834_32313130_30303800_00000000,  // 2.
    128'h00183020_20202020_311F0E00_00000000,  // 3.
    128'h00060505_04040404_3F3F0404_00000000,  // 4.
    128'h00193120_20202020_311F0E00_00000000,  // 5.
    128'h000F1F31_20202020_311F0E00_00000000,  // 6.
    128'h00000000_3C3F0300_00000000_00000000,  // 7.
    128'h000E1F31_20202020_311F0E00_00000000,  // 8.
    128'h00001131_22222222_331F0F00_00000000,  // 9.
    128'h20383F23_02022327_3C200000_00000000,  // A.
    128'h203F3F20_20202020_311F0E00_00000000,  // B.
    128'h071F3060_40404040_60301800_00000000,  // C.
    128'h203F3F20_20202030_180F0700_00000000,  // D.
    128'h203F3F20_20202023_20180000_00000000,  // E.
    128'h203F3F20_00000003_00000000_00000000   // F.
};

`endif

/* hdl/oled_pkg.sv */
`default_nettype none

package oled_pkg;

    typedef logic [7:0]   oled_byte_t;   // one byte on the spi link.
    typedef logic [7:0]   col_t;         // column 0..127.
    typedef logic [2:0]   page_t;        // page 0..7, wraps.
    typedef logic [3:0]   glyph_idx_t;   // one of 16 glyphs.
    typedef logic [127:0] glyph_half_t;  // 16 column bytes, first column in the top byte.
    typedef logic [4:0]   init_idx_t;    // config rom index.

    // sequencer states.
    // the order matters, simple steps advance by +1.
    typedef enum logic [3:0] {
        st_reset,       // panel reset hold.
        st_config,      // config bytes from rom.
        st_clr_page,
        st_clr_col_lo,
        st_clr_col_hi,
        st_clr_fill,    // 128 zero bytes.
        st_clr_next,
        st_top_page,
        st_top_col_hi,
        st_top_col_lo,
        st_top_data,
        st_btm_page,
        st_btm_col_hi,
        st_btm_col_lo,
        st_btm_data,
        st_done         // one cycle, done pulse.
    } seq_state_t;

endpackage

`default_nettype wire

/* hdl/spi_byte_if.sv */
`timescale 1ns/1ps
`default_nettype none

// one byte handoff, sequencer to spi transmitter.
// start is held with data and dc stable until done pulses.
interface spi_byte_if;
    import oled_pkg::*;

    logic       start;  // byte request.
    oled_byte_t data;   // byte to shift, msb first.
    logic       dc;     // 0 command, 1 display data.
    logic       done;   // one cycle, byte fully sent.

    modport seq (output start, output data, output dc, input done);
    modport phy (input start, input data, input dc, output done);

endinterface

`default_nettype wire

/* hdl/oled_init_rom.sv */
`timescale 1ns/1ps
`default_nettype none

module oled_init_rom (
    input  wire oled_pkg::init_idx_t addr,
    output oled_pkg::oled_byte_t     data,
    output logic                     dc
);

    localparam logic dc_cmd = 1'b0;  // all config bytes are commands.

    logic [8:0] entry;  // {dc, byte}.

    always_comb begin
        case (addr)
            5'd0:    entry = {dc_cmd, 8'hAE};  // display off.
            5'd1:    entry = {dc_cmd, 8'h00};  // column low nibble 0.
            5'd2:    entry = {dc_cmd, 8'h10};  // column high nibble 0.
            5'd3:    entry = {dc_cmd, 8'h40};  // start line 0.
            5'd4:    entry = {dc_cmd, 8'h2E};  // scroll off.
            5'd5:    entry = {dc_cmd, 8'h81};  // contrast,
            5'd6:    entry = {dc_cmd, 8'hCF};  // value.
            5'd7:    entry = {dc_cmd, 8'hA1};  // segment remap.
            5'd8:    entry = {dc_cmd, 8'hC8};  // com scan reversed.
            5'd9:    entry = {dc_cmd, 8'hA6};  // normal, not inverted.
            5'd10:   entry = {dc_cmd, 8'hA8};  // mux ratio,
            5'd11:   entry = {dc_cmd, 8'h3F};  // 64 rows.
            5'd12:   entry = {dc_cmd, 8'hD3};  // display offset,
            5'd13:   entry = {dc_cmd, 8'h00};  // none.
            5'd14:   entry = {dc_cmd, 8'hD5};  // clock divide,
            5'd15:   entry = {dc_cmd, 8'h80};
            5'd16:   entry = {dc_cmd, 8'hD9};  // precharge,
            5'd17:   entry = {dc_cmd, 8'hF1};
            5'd18:   entry = {dc_cmd, 8'hDA};  // com pins,
            5'd19:   entry = {dc_cmd, 8'h12};
            5'd20:   entry = {dc_cmd, 8'hDB};  // vcomh level,
            5'd21:   entry = {dc_cmd, 8'h40};
            5'd22:   entry = {dc_cmd, 8'h20};  // addressing mode,
            5'd23:   entry = {dc_cmd, 8'h02};  // page mode.
            5'd24:   entry = {dc_cmd, 8'h8D};  // charge pump,
            5'd25:   entry = {dc_cmd, 8'h14};  // on.
            5'd26:   entry = {dc_cmd, 8'hA4};  // show ram.
            5'd27:   entry = {dc_cmd, 8'hA6};
            5'd28:   entry = {dc_cmd, 8'hAF};  // display on.
            default: entry = {dc_cmd, 8'hAF};  // past end, display on.
        endcase
    end

    assign dc   = entry[8];
    assign data = entry[7:0];

endmodule

`default_nettype wire

/* hdl/oled_font_rom.sv */
`timescale 1ns/1ps
`default_nettype none

module oled_font_rom (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire oled_pkg::glyph_idx_t addr,
    output oled_pkg::glyph_half_t     data_top,
    output oled_pkg::glyph_half_t     data_btm
);

    `include "oled_font.svh"

    // one cycle lookup of both halves.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            data_top <= '0;
            data_btm <= '0;
        end else begin
            data_top <= oled_font_top[addr];
            data_btm <= oled_font_btm[addr];
        end
    end

endmodule

`default_nettype wire

/* hdl/spi_byte_tx.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_byte_tx (
    input  wire     clk,
    input  wire     rst_n,
    spi_byte_if.phy bus,
    output logic    cs_n,
    output logic    sclk,
    output logic    dc,
    output logic    sdin
);
    import oled_pkg::*;

    oled_byte_t shreg;    // outgoing bits, msb on the pin.
    logic [2:0] bit_cnt;  // bits already sent.
    logic       busy;     // cs low window.
    logic       fin;      // cs just rose.
    logic       done_q;
    logic       cs_q;
    logic       sclk_q;   // also the phase bit.
    logic       dc_q;

    ////////////////////
    // shifter
    ////////////////////

    // idle until start, then 16 cycles with cs low.
    // one cycle with cs high, then the done pulse.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy    <= 1'b0;
            fin     <= 1'b0;
            done_q  <= 1'b0;
            cs_q    <= 1'b1;
            sclk_q  <= 1'b0;
            dc_q    <= 1'b0;
            bit_cnt <= '0;
            shreg   <= '0;
        end else begin
            done_q <= fin;  // done one cycle after cs rises.
            fin    <= 1'b0;
            if (!busy) begin
                // start is still high around done, so ignore it then.
                if (bus.start && !fin && !done_q) begin
                    busy    <= 1'b1;
                    cs_q    <= 1'b0;
                    sclk_q  <= 1'b0;
                    bit_cnt <= '0;
                    shreg   <= bus.data;  // bit 7 on sdin right away.
                    dc_q    <= bus.dc;
                end
            end else if (!sclk_q) begin
                sclk_q <= 1'b1;  // rising edge, panel samples here.
            end else begin
                sclk_q  <= 1'b0;
                shreg   <= {shreg[6:0], 1'b0};  // next bit on the falling edge.
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt == 3'd7) begin
                    busy <= 1'b0;
                    cs_q <= 1'b1;
                    fin  <= 1'b1;
                end
            end
        end
    end

    assign cs_n     = cs_q;
    assign sclk     = sclk_q;
    assign dc       = dc_q;
    assign sdin     = shreg[7];  // all bits shifted out leaves it low.
    assign bus.done = done_q;

endmodule

`default_nettype wire

/* hdl/oled_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none
`include "oled_defs.svh"

module oled_sequencer (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        en,
    input  wire oled_pkg::glyph_idx_t  char_addr,
    input  wire oled_pkg::col_t        x,
    input  wire oled_pkg::page_t       y,
    input  wire oled_pkg::oled_byte_t  init_data,
    input  wire                        init_dc,
    input  wire oled_pkg::glyph_half_t glyph_top,
    input  wire oled_pkg::glyph_half_t glyph_btm,
    output oled_pkg::init_idx_t        init_addr,
    output oled_pkg::glyph_idx_t       glyph_addr,
    output logic                       oled_rst,
    output logic                       done,
    spi_byte_if.seq                    bus
);
    import oled_pkg::*;

    seq_state_t  state;
    logic [2:0]  rst_cnt;   // reset hold cycles.
    init_idx_t   init_idx;
    page_t       page_cnt;  // clear page.
    col_t        col_cnt;   // clear column.
    logic [3:0]  byte_cnt;  // glyph byte.
    glyph_half_t shreg;     // latched half, next byte on top.
    col_t        x_q;
    page_t       y_q;
    page_t       y_nxt;
    glyph_idx_t  glyph_q;
    logic        start_q;   // byte outstanding.
    oled_byte_t  data_q;
    logic        dc_q;
    oled_byte_t  nxt_byte;
    logic        nxt_dc;

    assign y_nxt = y_q + 3'd1;  // bottom half page, wraps.

    ////////////////////
    // next byte
    ////////////////////

    always_comb begin
        case (state)
            st_config:     nxt_byte = init_data;
            st_clr_page:   nxt_byte = 8'hB0 | {5'd0, page_cnt};
            st_clr_col_lo: nxt_byte = 8'h00;
            st_clr_col_hi: nxt_byte = 8'h10;
            st_top_page:   nxt_byte = 8'hB0 | {5'd0, y};  // live y, latched at this byte.
            st_btm_page:   nxt_byte = 8'hB0 | {5'd0, y_nxt};
            st_top_col_hi,
            st_btm_col_hi: nxt_byte = {4'h1, x_q[7:4]};
            st_top_col_lo,
            st_btm_col_lo: nxt_byte = {4'h0, x_q[3:0]};
            st_top_data,
            st_btm_data:   nxt_byte = shreg[127:120];
            default:       nxt_byte = 8'h00;  // clear fill.
        endcase
    end

    // data bytes go with dc high, commands low.
    assign nxt_dc = (state == st_config) ? init_dc
                  : (state inside {st_clr_fill, st_top_data, st_btm_data});

    ////////////////////
    // state machine
    ////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= st_reset;
            rst_cnt  <= '0;
            init_idx <= '0;
            page_cnt <= '0;
            col_cnt  <= '0;
            byte_cnt <= '0;
            shreg    <= '0;
            x_q      <= '0;
            y_q      <= '0;
            glyph_q  <= '0;
            start_q  <= 1'b0;
            data_q   <= '0;
            dc_q     <= 1'b0;
        end else if (start_q) begin
            // byte outstanding, only done moves us on, en or not.
            if (bus.done) begin
                start_q <= 1'b0;
                case (state)
                    st_config: begin
                        if (init_idx == init_idx_t'(`OLED_INIT_LEN - 1))
                            state <= st_clr_page;
                        else
                            init_idx <= init_idx + 1'b1;
                    end
                    st_clr_col_hi: begin
                        col_cnt <= '0;
                        state   <= st_clr_fill;
                    end
                    st_clr_fill: begin
                        if (col_cnt == col_t'(`OLED_COLS - 1))
                            state <= st_clr_next;
                        else
                            col_cnt <= col_cnt + 1'b1;
                    end
                    st_top_col_lo: begin
                        byte_cnt <= '0;
                        shreg    <= glyph_top;
                        state    <= st_top_data;
                    end
                    st_btm_col_lo: begin
                        byte_cnt <= '0;
                        shreg    <= glyph_btm;
                        state    <= st_btm_data;
                    end
                    st_top_data,
                    st_btm_data: begin
                        shreg    <= shreg << 8;
                        byte_cnt <= byte_cnt + 1'b1;
                        if (byte_cnt == 4'(`OLED_GLYPH_BYTES - 1))
                            state <= (state == st_top_data) ? st_btm_page : st_done;
                    end
                    default: state <= seq_state_t'(state + 4'd1);  // page -> col hi -> col lo.
                endcase
            end
        end else if (en) begin
            case (state)
                st_reset: begin
                    rst_cnt <= rst_cnt + 1'b1;
                    if (rst_cnt == 3'(`OLED_RESET_CYCLES - 1))
                        state <= st_config;
                end
                st_clr_next: begin
                    if (page_cnt == page_t'(`OLED_PAGES - 1)) begin
                        state <= st_top_page;
                    end else begin
                        page_cnt <= page_cnt + 1'b1;
                        state    <= st_clr_page;
                    end
                end
                st_done: state <= st_top_page;  // draw again, no init.
                default: begin
                    // byte states, raise the request.
                    start_q <= 1'b1;
                    data_q  <= nxt_byte;
                    dc_q    <= nxt_dc;
                    if (state == st_top_page) begin
                        x_q     <= x;  // position and glyph fixed for this draw.
                        y_q     <= y;
                        glyph_q <= char_addr;
                    end
                end
            endcase
        end
    end

    assign init_addr  = init_idx;
    assign glyph_addr = glyph_q;
    assign oled_rst   = (state != st_reset) || (rst_cnt >= 3'(`OLED_RESET_LOW));
    assign done       = en && (state == st_done);
    assign bus.start  = start_q && en;  // drops at once on pause.
    assign bus.data   = data_q;
    assign bus.dc     = dc_q;

endmodule

`default_nettype wire

/* hdl/oled_ctrl_top.sv */
`timescale 1ns/1ps
`default_nettype none

module oled_ctrl_top (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       en,         // high to run.
    input  wire oled_pkg::glyph_idx_t char_addr,  // glyph to draw.
    input  wire oled_pkg::col_t       x,          // column 0..127.
    input  wire oled_pkg::page_t      y,          // top page, bottom is y+1.
    output logic                      cs_n,
    output logic                      sclk,
    output logic                      dc,
    output logic                      sdin,
    output logic                      oled_rst,
    output logic                      done        // pulse per draw.
);
    import oled_pkg::*;

    init_idx_t   init_addr;
    oled_byte_t  init_data;
    logic        init_dc;
    glyph_idx_t  glyph_addr;
    glyph_half_t glyph_top;
    glyph_half_t glyph_btm;

    spi_byte_if byte_bus ();  // sequencer to transmitter.

    oled_sequencer oled_sequencer_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .en         (en),
        .char_addr  (char_addr),
        .x          (x),
        .y          (y),
        .init_data  (init_data),
        .init_dc    (init_dc),
        .glyph_top  (glyph_top),
        .glyph_btm  (glyph_btm),
        .init_addr  (init_addr),
        .glyph_addr (glyph_addr),
        .oled_rst   (oled_rst),
        .done       (done),
        .bus        (byte_bus.seq)
    );

    spi_byte_tx spi_byte_tx_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (byte_bus.phy),
        .cs_n  (cs_n),
        .sclk  (sclk),
        .dc    (dc),
        .sdin  (sdin)
    );

    oled_init_rom oled_init_rom_inst (
        .addr (init_addr),
        .data (init_data),
        .dc   (init_dc)
    );

    oled_font_rom oled_font_rom_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .addr     (glyph_addr),
        .data_top (glyph_top),
        .data_btm (glyph_btm)
    );

endmodule

`default_nettype wire

/* test/oled_ctrl_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module oled_ctrl_sva (
    input wire clk,
    input wire rst_n,
    input wire cs_n,
    input wire sclk,
    input wire sdin,
    input wire start,
    input wire done
);

    int fail_cnt = 0;  // failed assertions so far.

    // one byte keeps cs low for 16 clk cycles.
    cs_window: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(cs_n) |-> !cs_n [*16] ##1 cs_n)
        else begin
            fail_cnt++;
            $error("cs_n low window is not 16 clk cycles");
        end

    cs_from_start: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(cs_n) |-> $past(start))
        else begin
            fail_cnt++;
            $error("cs_n fell without a byte request");
        end

    sclk_idle: assert property (@(posedge clk) disable iff (!rst_n)
        cs_n |-> !sclk)  // clock parked low between bytes.
        else begin
            fail_cnt++;
            $error("sclk high while cs_n is high");
        end

    // panel samples on the rising edge.
    sdin_hold: assert property (@(posedge clk) disable iff (!rst_n)
        sclk |-> $stable(sdin))
        else begin
            fail_cnt++;
            $error("sdin changed while sclk was high");
        end

    done_after_cs: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(cs_n) |=> done)
        else begin
            fail_cnt++;
            $error("done did not follow the rise of cs_n");
        end

    done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        done |=> !done)
        else begin
            fail_cnt++;
            $error("done longer than one cycle");
        end

endmodule

`default_nettype wire

/* test/tb_oled_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none
`include "oled_defs.svh"

module tb_oled_ctrl;
    import oled_pkg::*;

    // the font rom already set the guard, so clear it for a local copy of the table.
    `undef OLED_FONT_SVH
    `include "oled_font.svh"

    localparam int n_fixed      = 6;
    localparam int n_random     = 3;
    localparam int n_draws      = n_fixed + n_random;
    localparam int pause_cycles = 120;  // en low time per paused draw.
    localparam int setup_bytes  = `OLED_INIT_LEN + `OLED_PAGES * (3 + `OLED_COLS);
    localparam int draw_bytes   = 2 * (3 + `OLED_GLYPH_BYTES);
    localparam int total_bytes  = setup_bytes + n_draws * draw_bytes;
    // about 20 clk cycles per byte, 40 ns each.
    localparam longint watchdog_ns = longint'(total_bytes * 20 + 2 * pause_cycles + 2000) * 40;

    typedef struct packed {
        glyph_idx_t ch;
        col_t       col;
        page_t      pg;
        page_t      btm_pg;  // expected page of the lower half.
        logic       pause;   // drop en mid draw.
    } draw_entry_t;

    // glyph, column, page, lower half page, pause.
    localparam logic [18:0] stim_tbl [n_fixed] = '{
        {4'h0, 8'd0,   3'd0, 3'd1, 1'b0},
        {4'h5, 8'd16,  3'd2, 3'd3, 1'b0},
        {4'hA, 8'd45,  3'd4, 3'd5, 1'b1},
        {4'hF, 8'd112, 3'd7, 3'd0, 1'b0},  // lower half wraps to page 0.
        {4'h8, 8'd127, 3'd6, 3'd7, 1'b0},
        {4'h3, 8'd64,  3'd1, 3'd2, 1'b1}
    };

    logic        clk;
    logic        rst_n;
    logic        en;
    glyph_idx_t  char_addr;
    col_t        x;
    page_t       y;
    logic        cs_n, sclk, dc, sdin, oled_rst, done;

    draw_entry_t draw_tbl [n_draws];
    logic [7:0]  exp_data [$];
    logic        exp_dc [$];
    logic        exp_care [$];  // init bytes in the middle are not compared.
    logic [7:0]  rx_data [$];
    logic        rx_dc [$];
    int          value_errors = 0;
    int          protocol_errors = 0;
    int          sva_errors = 0;
    int          checked = 0;
    int          done_cnt = 0;

    oled_ctrl_top oled_ctrl_top_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .en        (en),
        .char_addr (char_addr),
        .x         (x),
        .y         (y),
        .cs_n      (cs_n),
        .sclk      (sclk),
        .dc        (dc),
        .sdin      (sdin),
        .oled_rst  (oled_rst),
        .done      (done)
    );

    bind spi_byte_tx oled_ctrl_sva oled_ctrl_sva_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .cs_n  (cs_n),
        .sclk  (sclk),
        .sdin  (sdin),
        .start (bus.start),
        .done  (bus.done)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;  // 40 ns period.
    end

    ////////////////////
    // helpers
    ////////////////////

    task automatic report_mismatch(input string sig, input int unsigned got,
                                   input int unsigned want);
        value_errors++;
        $display("ERROR at %0t ns: %s = %0h, expected %0h", $time, sig, got, want);
    endtask

    task automatic report_failure(input string what);
        protocol_errors++;
        $display("ERROR at %0t ns: %s", $time, what);
    endtask

    task automatic push_expected(input logic [7:0] b, input logic d, input logic care);
        exp_data.push_back(b);
        exp_dc.push_back(d);
        exp_care.push_back(care);
    endtask

    // whole byte stream: config, clear, then one draw per entry.
    task automatic build_expected();
        glyph_half_t half;
        page_t       pg;
        for (int i = 0; i < `OLED_INIT_LEN; i++)
            push_expected((i == 0) ? 8'hAE : 8'hAF, 1'b0, (i == 0) || (i == `OLED_INIT_LEN - 1));
        for (int p = 0; p < `OLED_PAGES; p++) begin
            push_expected({5'b10110, 3'(p)}, 1'b0, 1'b1);
            push_expected(8'h00, 1'b0, 1'b1);
            push_expected(8'h10, 1'b0, 1'b1);
            for (int c = 0; c < `OLED_COLS; c++)
                push_expected(8'h00, 1'b1, 1'b1);  // blank column.
        end
        for (int i = 0; i < n_draws; i++) begin
            for (int h = 0; h < 2; h++) begin
                pg   = (h == 0) ? draw_tbl[i].pg : draw_tbl[i].btm_pg;
                half = (h == 0) ? oled_font_top[draw_tbl[i].ch] : oled_font_btm[draw_tbl[i].ch];
                push_expected({5'b10110, pg}, 1'b0, 1'b1);
                push_expected({4'h1, draw_tbl[i].col[7:4]}, 1'b0, 1'b1);
                push_expected({4'h0, draw_tbl[i].col[3:0]}, 1'b0, 1'b1);
                for (int b = 0; b < `OLED_GLYPH_BYTES; b++)
                    push_expected(half[127 - 8 * b -: 8], 1'b1, 1'b1);  // leftmost column first.
            end
        end
    endtask

    task automatic compare_bytes(input int upto);
        int last;
        last = (rx_data.size() < upto) ? rx_data.size() : upto;
        while (checked < last) begin
            assert (rx_dc[checked] == exp_dc[checked])
                else report_mismatch($sformatf("dc of byte %0d", checked),
                                     rx_dc[checked], exp_dc[checked]);
            if (exp_care[checked]) begin
                assert (rx_data[checked] == exp_data[checked])
                    else report_mismatch($sformatf("sdin byte %0d", checked),
                                         rx_data[checked], exp_data[checked]);
            end
            checked++;
        end
    endtask

    task automatic check_idle_outputs();
        assert (cs_n === 1'b1) else report_mismatch("cs_n", cs_n, 1);
        assert (sclk === 1'b0) else report_mismatch("sclk", sclk, 0);
        assert (dc === 1'b0) else report_mismatch("dc", dc, 0);
        assert (sdin === 1'b0) else report_mismatch("sdin", sdin, 0);
        assert (oled_rst === 1'b0) else report_mismatch("oled_rst", oled_rst, 0);
        assert (done === 1'b0) else report_mismatch("done", done, 0);
        assert (oled_ctrl_top_inst.byte_bus.start === 1'b0)
            else report_mismatch("start", oled_ctrl_top_inst.byte_bus.start, 0);
    endtask

    task automatic apply_entry(input int i);
        char_addr <= draw_tbl[i].ch;
        x         <= draw_tbl[i].col;
        y         <= draw_tbl[i].pg;
    endtask

    // done is sampled mid cycle.
    task automatic wait_for_done();
        @(negedge clk);
        while (done !== 1'b1)
            @(negedge clk);
    endtask

    ////////////////////
    // spi decoder
    ////////////////////

    logic [7:0] rx_shift = '0;
    int         rx_bits = 0;
    logic       in_byte = 1'b0;

    always @(negedge cs_n) begin
        rx_bits = 0;
        in_byte = 1'b1;
    end

    always @(posedge sclk) begin
        if (cs_n === 1'b0) begin
            rx_shift = {rx_shift[6:0], sdin};  // msb first.
            rx_bits++;
        end
    end

    always @(posedge cs_n) begin
        if (in_byte) begin
            in_byte = 1'b0;
            assert (rx_bits == 8) else report_mismatch("sclk rises per byte", rx_bits, 8);
            rx_data.push_back(rx_shift);
            rx_dc.push_back(dc);
        end
    end

    ////////////////////
    // pin monitor
    ////////////////////

    logic cs_prev = 1'b1;
    logic en_prev = 1'b0;
    logic done_prev = 1'b0;
    logic rst_seen_low = 1'b0;
    logic first_fall = 1'b1;
    int   low_cycles = 0;

    always @(negedge clk) begin
        if (rst_n) begin
            if (en && !oled_rst)
                rst_seen_low = 1'b1;  // panel reset pulse seen.
            if (cs_prev && !cs_n) begin
                assert (en_prev) else report_failure("cs_n fell while en was low");
                if (first_fall) begin
                    assert (rst_seen_low && oled_rst)
                        else report_failure("oled_rst did not pulse low before the first byte");
                end
                first_fall = 1'b0;
            end
            if (!cs_n) begin
                low_cycles++;
            end else if (low_cycles != 0) begin
                assert (low_cycles == 16) else report_mismatch("cs_n low cycles", low_cycles, 16);
                low_cycles = 0;
            end
            if (done && !done_prev)
                done_cnt++;
            assert (!(done && done_prev)) else report_failure("done stayed high past one cycle");
        end
        cs_prev   = cs_n;
        en_prev   = en;
        done_prev = done;
    end

    ////////////////////
    // stimulus
    ////////////////////

    initial begin
        int unsigned seed_ret;
        rst_n     = 1'b0;
        en        = 1'b0;
        char_addr = '0;
        x         = '0;
        y         = '0;
        seed_ret  = $urandom(46678);
        for (int i = 0; i < n_draws; i++) begin
            if (i < n_fixed) begin
                draw_tbl[i] = stim_tbl[i];
            end else begin
                draw_tbl[i].ch     = glyph_idx_t'($urandom % 16);
                draw_tbl[i].col    = col_t'($urandom % `OLED_COLS);
                draw_tbl[i].pg     = 3'd3;
                draw_tbl[i].btm_pg = 3'd4;
                draw_tbl[i].pause  = 1'b0;
            end
        end
        build_expected();
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_idle_outputs();  // en still low.
        @(posedge clk);
        apply_entry(0);
        en <= 1'b1;
        for (int i = 0; i < n_draws; i++) begin
            if (draw_tbl[i].pause) begin
                repeat (200) @(posedge clk);  // well inside the 38 byte draw.
                en <= 1'b0;
                repeat (pause_cycles) @(posedge clk);
                en <= 1'b1;
            end
            wait_for_done();
            assert (rx_data.size() == setup_bytes + (i + 1) * draw_bytes)
                else report_mismatch("bytes before done", rx_data.size(),
                                     setup_bytes + (i + 1) * draw_bytes);
            compare_bytes(setup_bytes + (i + 1) * draw_bytes);
            @(posedge clk);
            if (i + 1 < n_draws)
                apply_entry(i + 1);  // picked up at the next top page byte.
        end
        assert (done_cnt == n_draws) else report_mismatch("done pulses", done_cnt, n_draws);
        sva_errors = oled_ctrl_top_inst.spi_byte_tx_inst.oled_ctrl_sva_inst.fail_cnt;
        $display("errors: %0d value, %0d protocol, %0d assertion, %0d of %0d bytes compared",
                 value_errors, protocol_errors, sva_errors, checked, total_bytes);
        if (value_errors == 0 && protocol_errors == 0 && sva_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // watchdog.
    initial begin
        #(watchdog_ns);
        $display("watchdog expired after %0d ns, the byte stream stalled", watchdog_ns);
        $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
+incdir+include
hdl/oled_pkg.sv
hdl/spi_byte_if.sv
hdl/oled_init_rom.sv
hdl/oled_font_rom.sv
hdl/spi_byte_tx.sv
hdl/oled_sequencer.sv
hdl/oled_ctrl_top.sv
test/oled_ctrl_sva.sv
test/tb_oled_ctrl.sv

/* Bender.yml */
package:
  name: oled_ctrl

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/oled_pkg.sv
      - hdl/spi_byte_if.sv
      - hdl/oled_init_rom.sv
      - hdl/oled_font_rom.sv
      - hdl/spi_byte_tx.sv
      - hdl/oled_sequencer.sv
      - hdl/oled_ctrl_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/oled_ctrl_sva.sv
      - test/tb_oled_ctrl.sv
